/* hdl/organ_pkg.sv */
`default_nettype none

package organ_pkg;

  // ====================
  // Widths
  // ====================
  localparam int HALF_PERIOD_W  = 16;
  localparam int SAMPLE_COUNT_W = 16;
  localparam int SEG_DIGITS     = 6;
  localparam int APB_ADDR_W     = 4;
  localparam int APB_DATA_W     = 32;

  // Signed audio word sent to the codec side
  typedef logic signed [7:0] sample_t;

  // ====================
  // Register map
  // ====================
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL         = 4'h0;
  localparam logic [APB_ADDR_W-1:0] ADDR_CMD          = 4'h4;
  localparam logic [APB_ADDR_W-1:0] ADDR_NOTE_NAME    = 4'h8;
  localparam logic [APB_ADDR_W-1:0] ADDR_SAMPLE_COUNT = 4'hC;

  // ====================
  // Enums
  // ====================
  // Note codes in the old switch order, not a scale order
  typedef enum logic [2:0] {
    NOTE_DO_LO = 3'd0,
    NOTE_RE    = 3'd1,
    NOTE_FA    = 3'd2,
    NOTE_MI    = 3'd3,
    NOTE_LA    = 3'd4,
    NOTE_SI    = 3'd5,
    NOTE_SO    = 3'd6,
    NOTE_DO_HI = 3'd7
  } note_e;

  // Speed command opcodes in CMD[1:0]
  typedef enum logic [1:0] {
    SPEED_NOP   = 2'd0,
    SPEED_UP    = 2'd1,
    SPEED_DOWN  = 2'd2,
    SPEED_RESET = 2'd3
  } speed_op_e;

  // Bus phase as seen from psel and penable
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  // ====================
  // Defaults
  // ====================
  // 2 kHz sampling at 50 MHz
  localparam logic [SAMPLE_COUNT_W-1:0] DEFAULT_SAMPLE_COUNT = 16'd12499;
  localparam logic signed [SAMPLE_COUNT_W-1:0] SPEED_STEP = 16'sd100;

endpackage

`default_nettype wire

/* hdl/organ_apb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module organ_apb_regs import organ_pkg::*; (
  input  wire logic                      CLK_50M,
  input  wire logic                      rst,
  // APB slave side
  input  wire logic [APB_ADDR_W-1:0]     paddr,
  input  wire logic                      psel,
  input  wire logic                      penable,
  input  wire logic                      pwrite,
  input  wire logic [APB_DATA_W-1:0]     pwdata,
  output logic      [APB_DATA_W-1:0]     prdata,
  output logic                           pready,
  output logic                           pslverr,
  // Status from the datapath
  input  wire logic [15:0]               note_name,
  input  wire logic [SAMPLE_COUNT_W-1:0] sample_count,
  // Controls to the datapath
  output logic                           enable,
  output note_e                          note,
  output speed_op_e                      speed_op,
  output logic                           speed_valid
);

  apb_state_e apb_phase;
  logic       access;
  logic       addr_hit;
  logic       addr_ro;
  logic       acc_err;
  logic       wr_ok;

  // ====================
  // Phase and decode
  // ====================
  always_comb begin
    if (!psel) begin
      apb_phase = APB_IDLE;
    end else if (!penable) begin
      apb_phase = APB_SETUP;
    end else begin
      apb_phase = APB_ACCESS;
    end
  end

  assign access = (apb_phase == APB_ACCESS);

  // Four mapped words, two of them read only
  assign addr_hit = (paddr == ADDR_CTRL) || (paddr == ADDR_CMD) ||
                    (paddr == ADDR_NOTE_NAME) || (paddr == ADDR_SAMPLE_COUNT);
  assign addr_ro  = (paddr == ADDR_NOTE_NAME) || (paddr == ADDR_SAMPLE_COUNT);
  assign acc_err  = !addr_hit || (pwrite && addr_ro);

  // Zero wait states
  assign pready  = access;
  assign pslverr = access && acc_err;
  assign wr_ok   = access && pwrite && !acc_err;

  // ====================
  // Write side
  // ====================
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      enable      <= 1'b0;
      note        <= NOTE_DO_LO;
      speed_op    <= SPEED_NOP;
      speed_valid <= 1'b0;
    end else begin
      // Pulse by default, only one cycle per CMD write
      speed_valid <= 1'b0;
      if (wr_ok && (paddr == ADDR_CTRL)) begin
        enable <= pwdata[0];
        note   <= note_e'(pwdata[3:1]);
      end
      if (wr_ok && (paddr == ADDR_CMD)) begin
        speed_op <= speed_op_e'(pwdata[1:0]);
        // NOP writes are dropped here
        speed_valid <= (speed_op_e'(pwdata[1:0]) != SPEED_NOP);
      end
    end
  end

  // ====================
  // Read side
  // ====================
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (paddr)
        ADDR_CTRL:         prdata = {28'd0, note, enable};
        ADDR_NOTE_NAME:    prdata = {16'd0, note_name};
        ADDR_SAMPLE_COUNT: prdata = {16'd0, sample_count};
        // CMD reads back as zero
        default:           prdata = '0;
      endcase
    end
  end

  // Bus protocol from the master side
  a_penable_psel: assert property (@(posedge CLK_50M) disable iff (rst)
    penable |-> psel);

  // Back to back CMD writes still need a gap
  a_valid_pulse: assert property (@(posedge CLK_50M) disable iff (rst)
    speed_valid |=> !speed_valid);

endmodule

`default_nettype wire

/* hdl/note_table.sv */
`timescale 1ns/1ns
`default_nettype none

module note_table import organ_pkg::*; (
  input  note_e                    note,
  output logic [HALF_PERIOD_W-1:0] half_period,
  output logic [15:0]              note_name
);

  // ====================
  // Note lookup
  // ====================
  // Half-period counts in 50 MHz cycles
  // Names are two ASCII characters, upper one first
  always_comb begin
    half_period = 16'd47801;
    note_name   = "Do";
    case (note)
      NOTE_DO_LO: begin
        // About 523 Hz
        half_period = 16'd47801;
        note_name   = "Do";
      end
      NOTE_RE: begin
        half_period = 16'd42589;
        note_name   = "Re";
      end
      NOTE_MI: begin
        half_period = 16'd37936;
        note_name   = "Mi";
      end
      NOTE_FA: begin
        half_period = 16'd35817;
        note_name   = "Fa";
      end
      NOTE_SO: begin
        half_period = 16'd31928;
        note_name   = "So";
      end
      NOTE_LA: begin
        // Concert A, 880 Hz octave
        half_period = 16'd28409;
        note_name   = "La";
      end
      NOTE_SI: begin
        half_period = 16'd25329;
        note_name   = "Si";
      end
      NOTE_DO_HI: begin
        // One octave up from the low Do
        half_period = 16'd23901;
        note_name   = "Do";
      end
      default: begin
        half_period = 16'd47801;
        note_name   = "Do";
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/tone_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tone_gen import organ_pkg::*; (
  input  wire logic                     CLK_50M,
  input  wire logic                     rst,
  input  wire logic                     enable,
  input  note_e                         note,
  input  wire logic [HALF_PERIOD_W-1:0] half_period,
  output sample_t                       audio_sample
);

  logic [HALF_PERIOD_W-1:0] half_cnt;
  logic                     tone_level;
  note_e                    note_q;
  logic                     restart;

  // ====================
  // Half-period counter
  // ====================
  // Start over on any note change or while muted
  assign restart = !enable || (note != note_q);

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      half_cnt   <= '0;
      tone_level <= 1'b0;
      note_q     <= NOTE_DO_LO;
    end else begin
      note_q <= note;
      if (restart) begin
        half_cnt <= '0;
      end else if (half_cnt >= half_period) begin
        // Toggle every half_period+1 cycles
        half_cnt   <= '0;
        tone_level <= ~tone_level;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // ====================
  // Sample output
  // ====================
  // Full-scale square wave, silent when disabled
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      audio_sample <= 8'sh00;
    end else if (!enable) begin
      audio_sample <= 8'sh00;
    end else begin
      audio_sample <= tone_level ? 8'sh7F : 8'sh80;
    end
  end

  // Mute reaches the output one edge later
  a_mute: assert property (@(posedge CLK_50M) disable iff (rst)
    !enable |=> (audio_sample == 8'sh00));

endmodule

`default_nettype wire

/* hdl/speed_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module speed_ctrl import organ_pkg::*; (
  input  wire logic                      CLK_50M,
  input  wire logic                      rst,
  input  speed_op_e                      speed_op,
  input  wire logic                      speed_valid,
  output logic      [SAMPLE_COUNT_W-1:0] sample_count
);

  logic signed [SAMPLE_COUNT_W-1:0] speed_offset;

  // ====================
  // Offset register
  // ====================
  // Two's complement, wraps past either end
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      speed_offset <= '0;
    end else if (speed_valid) begin
      case (speed_op)
        SPEED_UP:    speed_offset <= speed_offset + SPEED_STEP;
        SPEED_DOWN:  speed_offset <= speed_offset - SPEED_STEP;
        SPEED_RESET: speed_offset <= '0;
        default:     speed_offset <= speed_offset;
      endcase
    end
  end

  // ====================
  // Sampling count
  // ====================
  // One edge behind the offset
  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      sample_count <= DEFAULT_SAMPLE_COUNT;
    end else begin
      sample_count <= DEFAULT_SAMPLE_COUNT + $unsigned(speed_offset);
    end
  end

endmodule

`default_nettype wire

/* hdl/hex_display.sv */
`timescale 1ns/1ns
`default_nettype none

module hex_display import organ_pkg::*; #(
  parameter int unsigned REFRESH_CYCLES = 25_000_000
) (
  input  wire logic                      CLK_50M,
  input  wire logic                      rst,
  input  wire logic [SAMPLE_COUNT_W-1:0] sample_count,
  output logic      [6:0]                hex0,
  output logic      [6:0]                hex1,
  output logic      [6:0]                hex2,
  output logic      [6:0]                hex3,
  output logic      [6:0]                hex4,
  output logic      [6:0]                hex5
);

  localparam int CNT_W  = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;
  localparam int DISP_W = SEG_DIGITS * 4;

  logic [CNT_W-1:0]  refresh_cnt;
  logic              refresh_tick;
  logic [DISP_W-1:0] disp_val;
  logic [6:0]        segs [SEG_DIGITS];

  // Active low, bit 0 is segment a
  function automatic logic [6:0] seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // ====================
  // Refresh timer
  // ====================
  assign refresh_tick = (refresh_cnt == CNT_W'(REFRESH_CYCLES - 1));

  always_ff @(posedge CLK_50M) begin
    if (rst) begin
      refresh_cnt <= '0;
      disp_val    <= '0;
    end else begin
      refresh_cnt <= refresh_tick ? '0 : refresh_cnt + 1'b1;
      // Hold the shown value between ticks
      if (refresh_tick) begin
        disp_val <= DISP_W'(sample_count);
      end
    end
  end

  // ====================
  // Digit decoders
  // ====================
  for (genvar d = 0; d < SEG_DIGITS; d++) begin : g_digit
    assign segs[d] = seg_decode(disp_val[d*4 +: 4]);
  end

  assign hex0 = segs[0];
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];
  assign hex4 = segs[4];
  assign hex5 = segs[5];

  a_refresh_range: assert property (@(posedge CLK_50M) disable iff (rst)
    refresh_cnt < REFRESH_CYCLES);

endmodule

`default_nettype wire

/* hdl/organ_top.sv */
`timescale 1ns/1ns
`default_nettype none

module organ_top import organ_pkg::*; #(
  parameter int unsigned REFRESH_CYCLES = 25_000_000
) (
  input  wire logic                  CLK_50M,
  input  wire logic                  rst,
  // APB slave
  input  wire logic [APB_ADDR_W-1:0] paddr,
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  pwrite,
  input  wire logic [APB_DATA_W-1:0] pwdata,
  output logic      [APB_DATA_W-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,
  // Audio and display
  output sample_t                    audio_sample,
  output logic      [6:0]            hex0,
  output logic      [6:0]            hex1,
  output logic      [6:0]            hex2,
  output logic      [6:0]            hex3,
  output logic      [6:0]            hex4,
  output logic      [6:0]            hex5
);

  logic                      enable;
  note_e                     note;
  speed_op_e                 speed_op;
  logic                      speed_valid;
  logic [HALF_PERIOD_W-1:0]  half_period;
  logic [15:0]               note_name;
  logic [SAMPLE_COUNT_W-1:0] sample_count;

  // ====================
  // Control
  // ====================
  organ_apb_regs i_regs (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .note_name    (note_name),
    .sample_count (sample_count),
    .enable       (enable),
    .note         (note),
    .speed_op     (speed_op),
    .speed_valid  (speed_valid)
  );

  // ====================
  // Datapath
  // ====================
  note_table i_note_table (
    .note        (note),
    .half_period (half_period),
    .note_name   (note_name)
  );

  tone_gen i_tone_gen (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .enable       (enable),
    .note         (note),
    .half_period  (half_period),
    .audio_sample (audio_sample)
  );

  // Count feeds both the display and the readback
  speed_ctrl i_speed_ctrl (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .speed_op     (speed_op),
    .speed_valid  (speed_valid),
    .sample_count (sample_count)
  );

  hex_display #(
    .REFRESH_CYCLES (REFRESH_CYCLES)
  ) i_hex_display (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .sample_count (sample_count),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

endmodule

`default_nettype wire

/* tb/tb_organ.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_organ import organ_pkg::*; ();

  localparam int unsigned REFRESH    = 64;
  localparam int          TONE_LIMIT = 60000;
  localparam int          APB_LIMIT  = 16;

  logic                  CLK_50M;
  logic                  rst;
  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  sample_t               audio_sample;
  logic [6:0]            hex0;
  logic [6:0]            hex1;
  logic [6:0]            hex2;
  logic [6:0]            hex3;
  logic [6:0]            hex4;
  logic [6:0]            hex5;
  logic [41:0]           hex_all;

  int          errors;
  int          checks;
  logic [15:0] exp_count;

  // Reference tables, indexed by note code or nibble
  logic [15:0] ref_count [8];
  logic [15:0] ref_name [8];
  logic [6:0]  ref_seg [16];

  assign hex_all = {hex5, hex4, hex3, hex2, hex1, hex0};

  // ====================
  // Clock and DUT
  // ====================
  initial begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  organ_top #(
    .REFRESH_CYCLES (REFRESH)
  ) i_dut (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .audio_sample (audio_sample),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  // ====================
  // Helpers
  // ====================
  task automatic load_tables();
    // Half-period counts in switch order
    ref_count[0] = 16'd47801;
    ref_count[1] = 16'd42589;
    ref_count[2] = 16'd35817;
    ref_count[3] = 16'd37936;
    ref_count[4] = 16'd28409;
    ref_count[5] = 16'd25329;
    ref_count[6] = 16'd31928;
    ref_count[7] = 16'd23901;
    ref_name[0] = "Do";
    ref_name[1] = "Re";
    ref_name[2] = "Fa";
    ref_name[3] = "Mi";
    ref_name[4] = "La";
    ref_name[5] = "Si";
    ref_name[6] = "So";
    ref_name[7] = "Do";
    // Active-low segments, a in bit 0
    ref_seg = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
  endtask

  function automatic logic [41:0] seg_pattern(input logic [23:0] value);
    logic [41:0] pat;
    for (int d = 0; d < 6; d++) begin
      pat[d*7 +: 7] = ref_seg[value[d*4 +: 4]];
    end
    return pat;
  endfunction

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  // One APB transfer, setup then access, back to idle on the falling edge
  task automatic apb_access(input logic [3:0] addr, input logic wr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    waits = 0;
    @(negedge CLK_50M);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge CLK_50M);
    penable = 1'b1;
    // Mid low phase, well clear of the access edge
    #5;
    while (!pready && waits < APB_LIMIT) begin
      @(negedge CLK_50M);
      #5;
      waits++;
    end
    if (!pready) begin
      abort_run("APB slave never raised pready");
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge CLK_50M);
    @(negedge CLK_50M);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] unused;
    logic        err;
    apb_access(addr, 1'b1, data, unused, err);
    check_value($sformatf("pslverr on write to 0x%0h", addr), err, exp_err);
  endtask

  task automatic apb_read(input logic [3:0] addr, input logic exp_err,
                          output logic [31:0] data);
    logic err;
    apb_access(addr, 1'b0, 32'd0, data, err);
    check_value($sformatf("pslverr on read of 0x%0h", addr), err, exp_err);
  endtask

  // Display may lag by up to one refresh period
  task automatic wait_display(input logic [23:0] value);
    int n;
    n = 0;
    while (hex_all !== seg_pattern(value) && n < REFRESH + 2) begin
      @(negedge CLK_50M);
      n++;
    end
    check_value($sformatf("display of 0x%0h", value), hex_all, seg_pattern(value));
  endtask

  // Call on a falling edge; counts cycles to the next sample change
  task automatic wait_sample_change(output int cycles);
    sample_t prev;
    prev   = audio_sample;
    cycles = 0;
    while (audio_sample === prev && cycles < TONE_LIMIT) begin
      @(negedge CLK_50M);
      cycles++;
    end
    if (audio_sample === prev) begin
      abort_run("audio_sample stopped changing");
    end
  endtask

  // ====================
  // Tests
  // ====================
  task automatic test_reset();
    logic [31:0] data;
    check_value("audio_sample after reset", {56'd0, audio_sample}, 64'd0);
    check_value("display after reset", hex_all, seg_pattern(24'd0));
    apb_read(ADDR_NOTE_NAME, 1'b0, data);
    check_value("NOTE_NAME after reset", data, {16'd0, ref_name[0]});
    apb_read(ADDR_SAMPLE_COUNT, 1'b0, data);
    check_value("SAMPLE_COUNT after reset", data, 32'd12499);
    // 12499 is 0x30D3
    wait_display(24'h0030D3);
  endtask

  task automatic test_tone(input logic [2:0] code);
    int cycles;
    logic full;
    apb_write(ADDR_CTRL, {28'd0, code, 1'b1}, 1'b0);
    // Unmuting is a change of its own
    if (audio_sample === 8'sh00) begin
      wait_sample_change(cycles);
    end
    // First toggle follows the restart, not a full half period
    wait_sample_change(cycles);
    repeat (2) begin
      wait_sample_change(cycles);
      check_value($sformatf("half period of code %0d", code), cycles,
                  ref_count[code] + 1);
      full = (audio_sample == 8'sh7F) || (audio_sample == 8'sh80);
      check_value($sformatf("sample 0x%0h is full scale", audio_sample), full, 1'b1);
    end
  endtask

  task automatic test_disable();
    int n;
    apb_write(ADDR_CTRL, 32'd0, 1'b0);
    n = 0;
    while (audio_sample !== 8'sh00 && n < 2) begin
      @(negedge CLK_50M);
      n++;
    end
    check_value("audio_sample after disable", {56'd0, audio_sample}, 64'd0);
    // Must stay silent
    for (n = 0; n < 100; n++) begin
      @(negedge CLK_50M);
      check_value("audio_sample while disabled", {56'd0, audio_sample}, 64'd0);
    end
  endtask

  task automatic test_note_names();
    int          order [8];
    int          i;
    int          j;
    int          tmp;
    logic [31:0] data;
    for (i = 0; i < 8; i++) begin
      order[i] = i;
    end
    // Shuffle with the seeded generator
    for (i = 7; i > 0; i--) begin
      j        = $urandom_range(i, 0);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (i = 0; i < 8; i++) begin
      apb_write(ADDR_CTRL, {28'd0, order[i][2:0], 1'b0}, 1'b0);
      apb_read(ADDR_CTRL, 1'b0, data);
      check_value("CTRL readback", data, {28'd0, order[i][2:0], 1'b0});
      apb_read(ADDR_NOTE_NAME, 1'b0, data);
      check_value($sformatf("NOTE_NAME for code %0d", order[i]), data,
                  {16'd0, ref_name[order[i]]});
    end
  endtask

  task automatic test_speed();
    speed_op_e   ops [10];
    int          offset;
    logic [31:0] data;
    ops = '{SPEED_UP, SPEED_UP, SPEED_DOWN, SPEED_NOP, SPEED_RESET,
            SPEED_DOWN, SPEED_DOWN, SPEED_DOWN, SPEED_DOWN, SPEED_UP};
    offset = 0;
    for (int k = 0; k < 10; k++) begin
      apb_write(ADDR_CMD, {30'd0, ops[k]}, 1'b0);
      case (ops[k])
        SPEED_UP:    offset = offset + 100;
        SPEED_DOWN:  offset = offset - 100;
        SPEED_RESET: offset = 0;
        default:     offset = offset;
      endcase
      exp_count = 16'(12499 + offset);
      // Offset then count, three edges after the access
      repeat (3) @(negedge CLK_50M);
      apb_read(ADDR_SAMPLE_COUNT, 1'b0, data);
      check_value($sformatf("SAMPLE_COUNT after op %0d", ops[k]), data, {16'd0, exp_count});
      wait_display({8'd0, exp_count});
    end
    apb_read(ADDR_CMD, 1'b0, data);
    check_value("CMD readback", data, 32'd0);
  endtask

  task automatic test_errors();
    logic [3:0]  bad;
    logic [31:0] data;
    // Known CTRL, note So and muted
    apb_write(ADDR_CTRL, 32'h0000000C, 1'b0);
    repeat (4) begin
      // Low two bits nonzero is never in the map
      bad = {2'($urandom_range(3, 0)), 2'($urandom_range(3, 1))};
      apb_write(bad, $urandom, 1'b1);
      apb_read(bad, 1'b1, data);
    end
    apb_write(ADDR_NOTE_NAME, 32'h0000FFFF, 1'b1);
    apb_write(ADDR_SAMPLE_COUNT, 32'h00000001, 1'b1);
    apb_read(ADDR_CTRL, 1'b0, data);
    check_value("CTRL after bad accesses", data, 32'h0000000C);
    apb_read(ADDR_NOTE_NAME, 1'b0, data);
    check_value("NOTE_NAME after bad accesses", data, {16'd0, ref_name[6]});
    apb_read(ADDR_SAMPLE_COUNT, 1'b0, data);
    check_value("SAMPLE_COUNT after bad accesses", data, {16'd0, exp_count});
  endtask

  // ====================
  // Sequence
  // ====================
  initial begin
    void'($urandom(32'h2cc47227));
    errors    = 0;
    checks    = 0;
    exp_count = 16'd12499;
    rst       = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    load_tables();
    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst = 1'b0;

    test_reset();
    test_tone(NOTE_DO_HI);
    test_tone(NOTE_LA);
    test_disable();
    test_note_names();
    test_speed();
    test_errors();

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hdl/organ_pkg.sv
hdl/organ_apb_regs.sv
hdl/note_table.sv
hdl/tone_gen.sv
hdl/speed_ctrl.sv
hdl/hex_display.sv
hdl/organ_top.sv
tb/tb_organ.sv

/* Makefile */
# Verilator flow for the organ voice

TOP := tb_organ

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module organ_top

sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
